/* bmq_config.svh */
// ====================================================================
// Build-time sizing macros for the branch-miss dispatch queue
// ====================================================================
`ifndef BMQ_CONFIG_SVH
`define BMQ_CONFIG_SVH

// Number of slots in the circular dispatch queue
// Must be a power of two between 4 and 16 so the pointers wrap naturally
`define BMQ_QENTRIES 8

// Width of a slot index, derived from the queue depth
`define BMQ_QBITS $clog2(`BMQ_QENTRIES)

// Width of the opaque payload carried with each operation
// The queue never looks inside it
`define BMQ_PAYLOAD_W 16

`endif

/* rtl/bmq_pkg.sv */
// ====================================================================
// Shared types of the dispatch queue: opcode, slot index and thread id
// ====================================================================
`default_nettype none

`include "bmq_config.svh"

package bmq_pkg;

    // Operation class as written by the front end
    // Only branches carry a prediction that the branch unit later checks
    typedef enum logic [1:0] {
        op_alu    = 2'd0,
        op_load   = 2'd1,
        op_store  = 2'd2,
        op_branch = 2'd3
    } op_e;

    // Position of an entry in the circular queue
    // Also used as the tag that the branch unit reports outcomes against
    typedef logic [`BMQ_QBITS-1:0] qidx_t;

    // Hardware thread that owns an entry
    // Two threads share the queue, so one bit is enough
    typedef logic thread_t;

endpackage

`default_nettype wire

/* rtl/branch_stomp.sv */
// ====================================================================
// Branch-miss stomp vector for the dispatch queue
// Purely combinational, marks younger same-thread entries for removal
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

`include "bmq_config.svh"

module branch_stomp (
    input  wire logic                      branchmiss,
    input  wire bmq_pkg::thread_t          miss_thread,
    input  wire bmq_pkg::qidx_t            miss_id,
    input  wire bmq_pkg::qidx_t            head,
    input  wire logic [`BMQ_QENTRIES-1:0]  slot_thread,
    input  wire logic [`BMQ_QENTRIES-1:0]  slot_valid,
    output logic      [`BMQ_QENTRIES-1:0]  stomp
);

    // Slots that lie strictly after the branch and before the head
    logic [`BMQ_QENTRIES-1:0] in_range;
    // Slots owned by the thread that took the miss
    logic [`BMQ_QENTRIES-1:0] same_thread;

    // ================================================================
    // Younger-than-branch window
    // ================================================================

    // Walking forward from the branch, everything up to the head is younger
    // than the branch, since the head marks the oldest live entry
    always_comb begin
        for (int n = 0; n < `BMQ_QENTRIES; n++) begin
            if (head == miss_id) begin
                // Branch sits at the head, so every other slot is younger
                in_range[n] = (bmq_pkg::qidx_t'(n) != miss_id);
            end else if (head > miss_id) begin
                // Window does not cross the top slot
                in_range[n] = (bmq_pkg::qidx_t'(n) > miss_id) &&
                              (bmq_pkg::qidx_t'(n) < head);
            end else begin
                // Window wraps past the top slot back to slot zero
                in_range[n] = (bmq_pkg::qidx_t'(n) > miss_id) ||
                              (bmq_pkg::qidx_t'(n) < head);
            end
        end
    end

    // ================================================================
    // Thread filter and final vector
    // ================================================================

    // The other thread did not follow the wrong path, so it keeps its entries
    always_comb begin
        for (int n = 0; n < `BMQ_QENTRIES; n++) begin
            same_thread[n] = (slot_thread[n] == miss_thread);
        end
    end

    // Only live entries are marked, so a slot filled during the miss cycle
    // is still invalid here and survives
    always_comb begin
        if (branchmiss) begin
            stomp = in_range & same_thread & slot_valid;
        end else begin
            stomp = '0;
        end
    end

endmodule

`default_nettype wire

/* rtl/branch_check.sv */
// ====================================================================
// Branch outcome check against the stored prediction
// Produces the resolve hit and the registered one-cycle miss report
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

`include "bmq_config.svh"

module branch_check (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      resolve_valid,
    input  wire bmq_pkg::qidx_t            resolve_id,
    input  wire logic                      resolve_taken,
    input  wire logic [`BMQ_QENTRIES-1:0]  slot_valid,
    input  wire logic [`BMQ_QENTRIES-1:0]  slot_branch,
    input  wire logic [`BMQ_QENTRIES-1:0]  slot_resolved,
    input  wire logic [`BMQ_QENTRIES-1:0]  slot_pred,
    input  wire logic [`BMQ_QENTRIES-1:0]  slot_thread,
    output logic                           resolve_hit,
    output logic                           branchmiss,
    output bmq_pkg::thread_t               miss_thread,
    output bmq_pkg::qidx_t                 miss_id
);

    // Outcome disagrees with what the front end predicted
    logic mispredict;

    // ================================================================
    // Resolve qualification
    // ================================================================

    // A report only counts for a live branch that has not been resolved yet
    // Stale or duplicate reports fall through without effect
    always_comb begin
        resolve_hit = resolve_valid &
                      slot_valid[resolve_id] &
                      slot_branch[resolve_id] &
                      ~slot_resolved[resolve_id];
    end

    // Compare the actual direction with the stored prediction bit
    always_comb begin
        mispredict = resolve_hit & (resolve_taken != slot_pred[resolve_id]);
    end

    // ================================================================
    // Registered miss
    // ================================================================

    // The miss lasts exactly one cycle, the cycle in which the stomp block
    // computes its vector and the queue holds back retirement
    always_ff @(posedge clk) begin
        if (rst) begin
            branchmiss  <= 1'b0;
            miss_thread <= '0;
            miss_id     <= '0;
        end else begin
            branchmiss <= mispredict;
            // Thread and index hold their last value between misses
            if (mispredict) begin
                miss_thread <= slot_thread[resolve_id];
                miss_id     <= resolve_id;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/dispatch_queue.sv */
// ====================================================================
// Circular dispatch queue with tail enqueue and in-order head retire
// Holds resolved bits and clears entries removed after a branch miss
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

`include "bmq_config.svh"

module dispatch_queue (
    input  wire logic                       clk,
    input  wire logic                       rst,

    // Enqueue port from the front end
    input  wire logic                       in_valid,
    output logic                            in_ready,
    input  wire bmq_pkg::thread_t           in_thread,
    input  wire bmq_pkg::op_e               in_op,
    input  wire logic                       in_pred_taken,
    input  wire logic [`BMQ_PAYLOAD_W-1:0]  in_payload,

    // Retire port toward the back end
    output logic                            out_valid,
    input  wire logic                       out_ready,
    output bmq_pkg::thread_t                out_thread,
    output bmq_pkg::op_e                    out_op,
    output logic      [`BMQ_PAYLOAD_W-1:0]  out_payload,

    // Resolve and miss handling
    input  wire logic                       resolve_hit,
    input  wire bmq_pkg::qidx_t             resolve_id,
    input  wire logic                       branchmiss,
    input  wire logic [`BMQ_QENTRIES-1:0]   stomp,

    // Slot state seen by the check and stomp blocks
    output logic      [`BMQ_QENTRIES-1:0]   slot_valid,
    output logic      [`BMQ_QENTRIES-1:0]   slot_thread,
    output logic      [`BMQ_QENTRIES-1:0]   slot_branch,
    output logic      [`BMQ_QENTRIES-1:0]   slot_resolved,
    output logic      [`BMQ_QENTRIES-1:0]   slot_pred,
    output bmq_pkg::qidx_t                  head
);

    // Opcode and payload of each slot
    bmq_pkg::op_e               slot_op      [`BMQ_QENTRIES];
    logic [`BMQ_PAYLOAD_W-1:0]  slot_payload [`BMQ_QENTRIES];

    // Next slot to be written by the front end
    bmq_pkg::qidx_t tail;

    // Handshake and head movement qualifiers
    logic enq_fire;
    logic ret_fire;
    logic head_ready;
    logic skip_head;

    // One-hot set and clear masks for the valid bits
    logic [`BMQ_QENTRIES-1:0] enq_set;
    logic [`BMQ_QENTRIES-1:0] ret_clr;
    logic [`BMQ_QENTRIES-1:0] res_set;

    // ================================================================
    // Decode of stored opcodes
    // ================================================================

    always_comb begin
        for (int n = 0; n < `BMQ_QENTRIES; n++) begin
            slot_branch[n] = (slot_op[n] == bmq_pkg::op_branch);
        end
    end

    // ================================================================
    // Port handshakes
    // ================================================================

    // The tail only reuses a slot once it is empty, including stomp holes
    assign in_ready = ~slot_valid[tail];
    assign enq_fire = in_valid & in_ready;

    // A branch may only leave once the branch unit has reported on it
    assign head_ready = ~slot_branch[head] | slot_resolved[head];

    // Retirement is held off for the miss cycle so the head cannot move
    // past the branch before the stomp has landed
    assign out_valid = slot_valid[head] & head_ready & ~branchmiss;
    assign ret_fire  = out_valid & out_ready;

    assign out_thread  = slot_thread[head];
    assign out_op      = slot_op[head];
    assign out_payload = slot_payload[head];

    // An empty head slot is stepped over while live entries remain ahead
    assign skip_head = ~slot_valid[head] & (|slot_valid);

    // ================================================================
    // Per-slot update masks
    // ================================================================

    always_comb begin
        for (int n = 0; n < `BMQ_QENTRIES; n++) begin
            enq_set[n] = enq_fire && (tail == bmq_pkg::qidx_t'(n));
            ret_clr[n] = ret_fire && (head == bmq_pkg::qidx_t'(n));
            res_set[n] = resolve_hit && (resolve_id == bmq_pkg::qidx_t'(n));
        end
    end

    // ================================================================
    // Control state
    // ================================================================

    // Stomp and retire never hit the same slot as an enqueue, since both
    // act on valid slots and an enqueue needs an empty one
    always_ff @(posedge clk) begin
        if (rst) begin
            slot_valid    <= '0;
            slot_resolved <= '0;
            head          <= '0;
            tail          <= '0;
        end else begin
            slot_valid <= (slot_valid & ~stomp & ~ret_clr) | enq_set;

            // A fresh entry starts unresolved, a hit marks it resolved
            slot_resolved <= (slot_resolved & ~enq_set) | res_set;

            if (enq_fire) begin
                tail <= tail + 1'b1;
            end

            // Pointers wrap on their own because the depth is a power of two
            if (ret_fire || skip_head) begin
                head <= head + 1'b1;
            end
        end
    end

    // ================================================================
    // Entry payload
    // ================================================================

    // Written only on an accepted enqueue and otherwise held
    always_ff @(posedge clk) begin
        if (enq_fire) begin
            slot_thread[tail]  <= in_thread;
            slot_pred[tail]    <= in_pred_taken;
            slot_op[tail]      <= in_op;
            slot_payload[tail] <= in_payload;
        end
    end

endmodule

`default_nettype wire

/* rtl/bmq_top.sv */
// ====================================================================
// Top level of the dispatch queue with branch-miss recovery
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

`include "bmq_config.svh"

module bmq_top (
    input  wire logic                       clk,
    input  wire logic                       rst,

    // Enqueue port
    input  wire logic                       in_valid,
    output logic                            in_ready,
    input  wire bmq_pkg::thread_t           in_thread,
    input  wire bmq_pkg::op_e               in_op,
    input  wire logic                       in_pred_taken,
    input  wire logic [`BMQ_PAYLOAD_W-1:0]  in_payload,

    // Retire port
    output logic                            out_valid,
    input  wire logic                       out_ready,
    output bmq_pkg::thread_t                out_thread,
    output bmq_pkg::op_e                    out_op,
    output logic      [`BMQ_PAYLOAD_W-1:0]  out_payload,

    // Resolve port, always accepted
    input  wire logic                       resolve_valid,
    input  wire bmq_pkg::qidx_t             resolve_id,
    input  wire logic                       resolve_taken,

    // Miss report toward fetch
    output logic                            miss_valid,
    output bmq_pkg::thread_t                miss_thread,
    output bmq_pkg::qidx_t                  miss_id
);

    // Slot state shared between the queue and the two helper blocks
    logic [`BMQ_QENTRIES-1:0] slot_valid;
    logic [`BMQ_QENTRIES-1:0] slot_thread;
    logic [`BMQ_QENTRIES-1:0] slot_branch;
    logic [`BMQ_QENTRIES-1:0] slot_resolved;
    logic [`BMQ_QENTRIES-1:0] slot_pred;
    bmq_pkg::qidx_t           head;

    // Feedback from the check and stomp blocks into the queue
    logic                     resolve_hit;
    logic [`BMQ_QENTRIES-1:0] stomp;

    // The registered miss pulse doubles as the outside miss_valid
    dispatch_queue u_queue (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_thread     (in_thread),
        .in_op         (in_op),
        .in_pred_taken (in_pred_taken),
        .in_payload    (in_payload),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_thread    (out_thread),
        .out_op        (out_op),
        .out_payload   (out_payload),
        .resolve_hit   (resolve_hit),
        .resolve_id    (resolve_id),
        .branchmiss    (miss_valid),
        .stomp         (stomp),
        .slot_valid    (slot_valid),
        .slot_thread   (slot_thread),
        .slot_branch   (slot_branch),
        .slot_resolved (slot_resolved),
        .slot_pred     (slot_pred),
        .head          (head)
    );

    branch_check u_check (
        .clk           (clk),
        .rst           (rst),
        .resolve_valid (resolve_valid),
        .resolve_id    (resolve_id),
        .resolve_taken (resolve_taken),
        .slot_valid    (slot_valid),
        .slot_branch   (slot_branch),
        .slot_resolved (slot_resolved),
        .slot_pred     (slot_pred),
        .slot_thread   (slot_thread),
        .resolve_hit   (resolve_hit),
        .branchmiss    (miss_valid),
        .miss_thread   (miss_thread),
        .miss_id       (miss_id)
    );

    // Stomp vector is consumed by the queue at the end of the miss cycle
    branch_stomp u_stomp (
        .branchmiss  (miss_valid),
        .miss_thread (miss_thread),
        .miss_id     (miss_id),
        .head        (head),
        .slot_thread (slot_thread),
        .slot_valid  (slot_valid),
        .stomp       (stomp)
    );

endmodule

`default_nettype wire

/* sim/bmq_assert.sv */
// ====================================================================
// Concurrent checks on the dispatch queue and its miss handling,
// attached to every dispatch_queue instance with bind
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

`include "bmq_config.svh"

module bmq_assert (
    input wire logic                      clk,
    input wire logic                      rst,
    input wire logic                      out_valid,
    input wire logic                      in_ready,
    input wire logic                      branchmiss,
    input wire bmq_pkg::qidx_t            resolve_id,
    input wire bmq_pkg::qidx_t            tail,
    input wire logic [`BMQ_QENTRIES-1:0]  stomp,
    input wire logic [`BMQ_QENTRIES-1:0]  slot_valid
);

    // Failed assertions, read by the testbench at the end of the run
    int fail_count = 0;

    // Nothing may leave the queue while the stomp is still pending
    a_no_retire_in_miss: assert property (@(posedge clk) disable iff (rst)
        branchmiss |-> !out_valid)
        else begin
            $error("out_valid is high in a branch-miss cycle");
            fail_count++;
        end

    // The miss index is the resolve index one cycle earlier
    // and the branch itself must survive its own stomp
    a_branch_kept: assert property (@(posedge clk) disable iff (rst)
        branchmiss |-> !stomp[$past(resolve_id)])
        else begin
            $error("stomp vector removes the missing branch itself");
            fail_count++;
        end

    a_ready_tracks_tail: assert property (@(posedge clk) disable iff (rst)
        in_ready == !slot_valid[tail])
        else begin
            $error("in_ready disagrees with the valid bit of the tail slot");
            fail_count++;
        end

endmodule

bind dispatch_queue bmq_assert u_assert (
    .clk        (clk),
    .rst        (rst),
    .out_valid  (out_valid),
    .in_ready   (in_ready),
    .branchmiss (branchmiss),
    .resolve_id (resolve_id),
    .tail       (tail),
    .stomp      (stomp),
    .slot_valid (slot_valid)
);

`default_nettype wire

/* sim/bmq_tb.sv */
// ====================================================================
// Testbench for the dispatch queue with xorshift stimulus, a slot-level
// reference model, a comparing process and one report line per test
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

`include "bmq_config.svh"

module bmq_tb;

    localparam int N = `BMQ_QENTRIES;

    logic clk = 1'b0;
    logic rst, in_valid, in_ready, in_pred_taken, out_valid, out_ready;
    logic resolve_valid, resolve_taken, miss_valid;
    bmq_pkg::thread_t in_thread, out_thread, miss_thread;
    bmq_pkg::op_e in_op, out_op;
    bmq_pkg::qidx_t resolve_id, miss_id;
    logic [`BMQ_PAYLOAD_W-1:0] in_payload, out_payload;

    // ================================================================
    // Reference model with one record per slot and age as a sequence number
    // ================================================================
    logic m_valid [N];
    logic m_res [N];
    logic m_pred [N];
    bmq_pkg::thread_t m_thread [N];
    bmq_pkg::op_e m_op [N];
    logic [`BMQ_PAYLOAD_W-1:0] m_pay [N];
    int m_seq [N];
    int m_tail = 0;
    int m_count = 0;
    int seq_next = 0;

    // Miss expected in the coming cycle with its thread and index
    logic exp_miss = 1'b0;
    logic exp_thread;
    int exp_id;

    logic [31:0] rng = 32'hb3afc50c;
    logic [31:0] rdy_rng = ~32'hb3afc50c;
    int ready_mode = 0;
    int n_ops = 0;
    int cycles = 0;
    int errors = 0;
    int err_mark = 0;
    int tests_ok = 0;
    int tests_bad = 0;
    string cur_test = "reset";
    int s;
    int b;
    logic t;

    bmq_top dut_i (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // Oldest live entry by enqueue order or -1 when the model is empty
    function automatic int oldest_slot();
        int best = -1;
        for (int n = 0; n < N; n++) begin
            if (m_valid[n] && (best < 0 || m_seq[n] < m_seq[best])) best = n;
        end
        return best;
    endfunction

    // Live entries of the branch's thread that were enqueued after it
    function automatic logic [N-1:0] stomp_mask(input int br);
        logic [N-1:0] mask;
        for (int n = 0; n < N; n++) begin
            mask[n] = m_valid[n] && m_thread[n] == m_thread[br] && m_seq[n] > m_seq[br];
        end
        return mask;
    endfunction

    // Assertion failures of the bound checker count as errors too
    function automatic int total_errors();
        return errors + dut_i.u_queue.u_assert.fail_count;
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("FAIL %s expected %0h actual %0h (%s)", cur_test, exp, act, what);
            errors++;
        end
    endtask

    task automatic check_idle();
        check_value("in_ready", 1, in_ready);
        check_value("out_valid", 0, out_valid);
        check_value("miss_valid", 0, miss_valid);
    endtask

    // Offers one entry and returns the slot it landed in once accepted
    task automatic push_op(input logic thr, input bmq_pkg::op_e op, output int slot);
        logic acc;
        rng = xorshift32(rng);
        in_valid = 1'b1;
        in_thread = thr;
        in_op = op;
        in_pred_taken = rng[0];
        in_payload = `BMQ_PAYLOAD_W'(rng >> 8);
        n_ops++;
        do begin
            @(negedge clk);
            acc = in_ready;
            @(posedge clk);
            #2;
        end while (!acc);
        in_valid = 1'b0;
        slot = (m_tail + N - 1) % N;
    endtask

    task automatic send_resolve(input int slot, input logic taken);
        resolve_valid = 1'b1;
        resolve_id = bmq_pkg::qidx_t'(slot);
        resolve_taken = taken;
        n_ops++;
        @(posedge clk);
        #2;
        resolve_valid = 1'b0;
    endtask

    task automatic drain();
        while (m_count != 0) begin
            @(posedge clk);
            #2;
        end
        repeat (2) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        err_mark = total_errors();
    endtask

    task automatic end_test();
        if (total_errors() == err_mark) begin
            $display("test %s: ok", cur_test);
            tests_ok++;
        end else begin
            $display("test %s: %0d errors", cur_test, total_errors() - err_mark);
            tests_bad++;
        end
    endtask

    // ================================================================
    // Retire pressure held low, held high or random
    // ================================================================
    always @(posedge clk) begin : ready_drive
        int mode_now;
        mode_now = ready_mode;
        #2;
        rdy_rng = xorshift32(rdy_rng);
        out_ready = (mode_now == 2) ? (rdy_rng[3] | rdy_rng[9]) : mode_now[0];
    end

    // Limit grows with every operation issued
    always @(posedge clk) begin : watchdog
        cycles++;
        if (cycles > 20 * n_ops + 200) begin
            $display("Timeout in test %s: no progress after %0d cycles", cur_test, cycles);
            $display("Regression failed");
            $finish;
        end
    end

    // ================================================================
    // Comparing process sampled at the falling edge before each rising edge
    // ================================================================
    always @(negedge clk) begin : compare
        int o;
        int rid;
        logic [N-1:0] kill;
        if (!rst) begin
            check_value("miss_valid", exp_miss, miss_valid);
            if (exp_miss) begin
                check_value("miss_thread", exp_thread, miss_thread);
                check_value("miss_id", exp_id, miss_id);
            end
            exp_miss = 1'b0;
            // Retire first, since it takes the oldest entry
            if (out_valid && out_ready) begin
                o = oldest_slot();
                assert (o >= 0) else begin
                    $display("ERROR in %s: DUT retired an entry the model does not hold",
                             cur_test);
                    errors++;
                end
                if (o >= 0) begin
                    assert (m_op[o] != bmq_pkg::op_branch || m_res[o]) else begin
                        $display("ERROR in %s: branch in slot %0d retired before its resolve",
                                 cur_test, o);
                        errors++;
                    end
                    check_value("out_payload", m_pay[o], out_payload);
                    check_value("out_thread", m_thread[o], out_thread);
                    check_value("out_op", m_op[o], out_op);
                    m_valid[o] = 1'b0;
                    m_count--;
                end
            end
            if (in_valid && in_ready) begin
                assert (!m_valid[m_tail]) else begin
                    $display("ERROR in %s: enqueue accepted into live slot %0d", cur_test, m_tail);
                    errors++;
                end
                m_valid[m_tail] = 1'b1;
                m_res[m_tail] = 1'b0;
                m_pred[m_tail] = in_pred_taken;
                m_thread[m_tail] = in_thread;
                m_op[m_tail] = in_op;
                m_pay[m_tail] = in_payload;
                m_seq[m_tail] = seq_next;
                seq_next++;
                m_tail = (m_tail + 1) % N;
                m_count++;
            end
            // Resolve last, so an entry enqueued at the same edge is stomped
            rid = resolve_id;
            if (resolve_valid && m_valid[rid] && m_op[rid] == bmq_pkg::op_branch
                && !m_res[rid]) begin
                m_res[rid] = 1'b1;
                if (resolve_taken != m_pred[rid]) begin
                    kill = stomp_mask(rid);
                    for (int n = 0; n < N; n++) begin
                        if (kill[n]) begin
                            m_valid[n] = 1'b0;
                            m_count--;
                        end
                    end
                    exp_miss = 1'b1;
                    exp_thread = m_thread[rid];
                    exp_id = rid;
                end
            end
        end
    end

    // ================================================================
    // Test sequence
    // ================================================================
    initial begin
        rst = 1'b1;
        in_valid = 1'b0;
        in_thread = 1'b0;
        in_op = bmq_pkg::op_alu;
        in_pred_taken = 1'b0;
        in_payload = '0;
        out_ready = 1'b0;
        resolve_valid = 1'b0;
        resolve_id = '0;
        resolve_taken = 1'b0;
        for (int n = 0; n < N; n++) begin
            m_valid[n] = 1'b0;
        end

        begin_test("reset");
        repeat (8) begin
            @(posedge clk);
            #2;
            check_idle();
        end
        rst = 1'b0;
        @(posedge clk);
        #2;
        check_idle();
        end_test();

        // Loads, stores and ALU ops of both threads under random retire pressure
        begin_test("in_order");
        ready_mode = 2;
        repeat (24) begin
            rng = xorshift32(rng);
            push_op(rng[0], bmq_pkg::op_e'((rng[2:1] == 2'd3) ? 2'd0 : rng[2:1]), s);
        end
        drain();
        end_test();

        // Stray resolves to a load and repeated resolves must be ignored
        begin_test("predict");
        repeat (8) begin
            rng = xorshift32(rng);
            push_op(rng[0], bmq_pkg::op_branch, b);
            push_op(rng[1], bmq_pkg::op_load, s);
            send_resolve(s, ~m_pred[s]);
            send_resolve(b, m_pred[b]);
            send_resolve(b, ~m_pred[b]);
        end
        drain();
        end_test();

        // Branch first into an empty queue, so it is at the head when it misses
        begin_test("miss_head");
        ready_mode = 1;
        rng = xorshift32(rng);
        t = rng[0];
        push_op(t, bmq_pkg::op_branch, b);
        // Threads alternate so that both stomped and surviving entries follow the branch
        for (int k = 0; k < N - 2; k++) begin
            push_op(t ^ k[0], bmq_pkg::op_alu, s);
        end
        send_resolve(b, ~m_pred[b]);
        drain();
        end_test();

        // Older entry at N-3 holds the head while the live range wraps
        begin_test("miss_wrap");
        while (m_tail != N - 3) begin
            push_op(1'b0, bmq_pkg::op_alu, s);
        end
        drain();
        ready_mode = 0;
        rng = xorshift32(rng);
        t = rng[0];
        push_op(t, bmq_pkg::op_alu, s);
        push_op(t, bmq_pkg::op_branch, b);
        push_op(t, bmq_pkg::op_store, s);
        push_op(~t, bmq_pkg::op_load, s);
        if (N > 4) begin
            push_op(t, bmq_pkg::op_alu, s);
            push_op(~t, bmq_pkg::op_alu, s);
        end
        send_resolve(b, ~m_pred[b]);
        ready_mode = 2;
        drain();
        end_test();

        begin_test("back_pressure");
        ready_mode = 0;
        repeat (N) begin
            rng = xorshift32(rng);
            push_op(rng[0], bmq_pkg::op_store, s);
        end
        repeat (3) begin
            check_value("in_ready", 0, in_ready);
            @(posedge clk);
            #2;
        end
        ready_mode = 1;
        repeat (4) begin
            rng = xorshift32(rng);
            push_op(rng[0], bmq_pkg::op_load, s);
        end
        drain();
        end_test();

        $display("tests ok %0d, tests failed %0d, failed checks %0d",
                 tests_ok, tests_bad, total_errors());
        if (total_errors() == 0 && tests_bad == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+.
rtl/bmq_pkg.sv
rtl/branch_stomp.sv
rtl/branch_check.sv
rtl/dispatch_queue.sv
rtl/bmq_top.sv
sim/bmq_assert.sv
sim/bmq_tb.sv

/* Bender.yml */
package:
  name: bmq

export_include_dirs:
  - .

sources:
  - files:
      - rtl/bmq_pkg.sv
      - rtl/branch_stomp.sv
      - rtl/branch_check.sv
      - rtl/dispatch_queue.sv
      - rtl/bmq_top.sv
  - target: simulation
    files:
      - sim/bmq_assert.sv
      - sim/bmq_tb.sv
